/* Bender.yml */
package:
  name: instr_prefetch

sources:
  - include_dirs:
      - src
    files:
      - src/fetch_pkg.sv
      - src/fetch_requester.sv
      - src/fetch_fifo.sv
      - src/issue_reg.sv
      - src/prefetch_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/prefetch_checker.sv
      - verification/prefetch_tb.sv

/* src/fetch_consts.svh */
// shared fetch constants, pulled in with `include by the RTL and the testbench
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// address and instruction data width
`define FETCH_ADDR_W 32

// fetch FIFO entries
// the ready/overflow scheme needs at least 3
`define FETCH_DEPTH 4

// first word fetched after reset, word aligned
`define FETCH_BOOT_ADDR 32'h0000_0080

// memory word size in bytes
`define FETCH_WORD_BYTES 4

`endif

/* src/fetch_fifo.sv */
// processing part of the prefetcher, buffers fetched words, realigns and sizes instructions
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_fifo (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     clear_i,
  // from requester
  input  logic                     in_valid_i,
  input  logic [`FETCH_ADDR_W-1:0] in_addr_i,
  input  logic [`FETCH_ADDR_W-1:0] in_rdata_i,
  output logic                     in_ready_o,
  // to issue register
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic [`FETCH_ADDR_W-1:0] out_rdata_o,
  output logic [`FETCH_ADDR_W-1:0] out_addr_o,
  output fetch_pkg::instr_kind_e   out_kind_o
);

  // entry 0 is the head
  logic [`FETCH_ADDR_W-1:0] addr_q   [`FETCH_DEPTH];
  logic [`FETCH_ADDR_W-1:0] addr_int [`FETCH_DEPTH];
  logic [`FETCH_ADDR_W-1:0] addr_n   [`FETCH_DEPTH];
  logic [`FETCH_ADDR_W-1:0] rdata_q  [`FETCH_DEPTH];
  logic [`FETCH_ADDR_W-1:0] rdata_int[`FETCH_DEPTH];
  logic [`FETCH_ADDR_W-1:0] rdata_n  [`FETCH_DEPTH];
  logic [`FETCH_DEPTH-1:0]  valid_q, valid_int, valid_n;

  logic [`FETCH_ADDR_W-1:0] head_rdata;
  logic [15:0]              second_half;
  logic [`FETCH_ADDR_W-1:0] addr_next;
  logic                     head_valid;
  logic                     second_valid;
  logic                     is_comp;
  logic                     transfer;

  ////////////////////
  // output / aligner
  ////////////////////

  // empty FIFO passes the incoming word straight through
  assign head_rdata = valid_q[0] ? rdata_q[0] : in_rdata_i;
  assign head_valid = valid_q[0] || in_valid_i;
  assign out_addr_o = valid_q[0] ? addr_q[0] : in_addr_i;

  // lower half of the following word, stored or just arriving
  assign second_half  = valid_q[1] ? rdata_q[1][15:0] : in_rdata_i[15:0];
  assign second_valid = valid_q[1] || (valid_q[0] && in_valid_i);

  assign is_comp = out_addr_o[1] ? (head_rdata[17:16] != 2'b11) : (head_rdata[1:0] != 2'b11);

  always_comb begin
    if (out_addr_o[1]) begin
      out_rdata_o = {second_half, head_rdata[31:16]};
      // full instruction across the boundary waits for its upper half
      out_valid_o = is_comp ? head_valid : second_valid;
    end else begin
      out_rdata_o = head_rdata;
      out_valid_o = head_valid;
    end
  end

  assign out_kind_o = is_comp ? fetch_pkg::KIND_COMP : fetch_pkg::KIND_FULL;
  assign transfer   = out_valid_o && out_ready_i;

  // one spare slot covers the read already in flight
  assign in_ready_o = !valid_q[`FETCH_DEPTH-2];

  ////////////////////
  // FIFO management
  ////////////////////

  // write the incoming word into the first free slot
  always_comb begin
    logic placed;
    placed    = 1'b0;
    addr_int  = addr_q;
    rdata_int = rdata_q;
    valid_int = valid_q;
    if (in_valid_i) begin
      for (int i = 0; i < `FETCH_DEPTH; i++) begin
        if (!valid_q[i] && !placed) begin
          addr_int[i]  = in_addr_i;
          rdata_int[i] = in_rdata_i;
          valid_int[i] = 1'b1;
          placed       = 1'b1;
        end
      end
    end
  end

  assign addr_next = {addr_int[0][`FETCH_ADDR_W-1:2], 2'b00} + `FETCH_WORD_BYTES;

  // advance the head, shifting only once a word is used up
  always_comb begin
    addr_n  = addr_int;
    rdata_n = rdata_int;
    valid_n = valid_int;
    if (transfer) begin
      if (!addr_int[0][1] && is_comp) begin
        // upper half of the same word is next
        addr_n[0] = {addr_int[0][`FETCH_ADDR_W-1:2], 2'b10};
      end else begin
        for (int i = 0; i < `FETCH_DEPTH - 1; i++) begin
          addr_n[i]  = addr_int[i+1];
          rdata_n[i] = rdata_int[i+1];
        end
        valid_n = valid_int >> 1;
        // an unaligned full one also ate the low half of the next word
        addr_n[0] = {addr_next[`FETCH_ADDR_W-1:2], addr_int[0][1] && !is_comp, 1'b0};
      end
    end
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (clear_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_n;
    end
  end

  always_ff @(posedge clk) begin
    addr_q  <= addr_n;
    rdata_q <= rdata_n;
  end

  // requester throttling must keep the last slot free
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n) in_valid_i |-> (!valid_q[`FETCH_DEPTH-1] || clear_i)
  );

endmodule

/* src/fetch_pkg.sv */
// enum types shared by the prefetch RTL and the checker, used by scoped name
package fetch_pkg;

  ////////////////////
  // requester FSM
  ////////////////////

  // RESET_WAIT  first cycle after reset, no request yet
  // RUN         sequential fetch
  // HOLD        FIFO full, waiting for room
  typedef enum logic [1:0] {
    RESET_WAIT = 2'd0,
    RUN        = 2'd1,
    HOLD       = 2'd2
  } req_state_e;

  ////////////////////
  // instruction length
  ////////////////////

  // compressed when the low two bits are not 2'b11
  typedef enum logic {
    KIND_COMP = 1'b0,
    KIND_FULL = 1'b1
  } instr_kind_e;

endpackage

/* src/fetch_requester.sv */
// input side of the prefetcher, issues word reads and tags each response with its address
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_requester (
  input  logic                     clk,
  input  logic                     rst_n,
  // redirect
  input  logic                     branch_i,
  input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
  // memory side
  output logic                     mem_req_o,
  output logic [`FETCH_ADDR_W-1:0] mem_addr_o,
  input  logic                     mem_rvalid_i,
  input  logic [`FETCH_ADDR_W-1:0] mem_rdata_i,
  // FIFO side
  input  logic                     fifo_ready_i,
  output logic                     fifo_valid_o,
  output logic [`FETCH_ADDR_W-1:0] fifo_addr_o,
  output logic [`FETCH_ADDR_W-1:0] fifo_rdata_o
);

  fetch_pkg::req_state_e state_q, state_d;

  logic [`FETCH_ADDR_W-1:0] next_addr_q;  // word address of the next read
  logic [`FETCH_ADDR_W-1:0] req_addr_q;   // tag for the response in flight
  logic                     hw_q;         // pending halfword offset from a redirect
  logic                     in_flight_q;
  logic                     discard_q;
  logic                     slot_free;

  // the outstanding read frees its slot in the cycle its data lands
  assign slot_free = !in_flight_q || mem_rvalid_i;

  ////////////////////
  // request FSM
  ////////////////////

  always_comb begin
    state_d   = state_q;
    mem_req_o = 1'b0;
    case (state_q)
      fetch_pkg::RESET_WAIT: begin
        state_d = fetch_pkg::RUN;
      end
      fetch_pkg::RUN: begin
        mem_req_o = fifo_ready_i && slot_free;
        if (!fifo_ready_i) state_d = fetch_pkg::HOLD;
      end
      fetch_pkg::HOLD: begin
        // FIFO drained below the threshold, resume right away
        mem_req_o = fifo_ready_i && slot_free;
        if (fifo_ready_i) state_d = fetch_pkg::RUN;
      end
      default: begin
        state_d = fetch_pkg::RESET_WAIT;
      end
    endcase
    // a redirect always restarts sequential fetch
    if (branch_i) state_d = fetch_pkg::RUN;
  end

  assign mem_addr_o = next_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= fetch_pkg::RESET_WAIT;
      next_addr_q <= `FETCH_BOOT_ADDR;
      hw_q        <= 1'b0;
      in_flight_q <= 1'b0;
      discard_q   <= 1'b0;
    end else begin
      state_q     <= state_d;
      in_flight_q <= mem_req_o;
      // response in the cycle after a redirect is from the old stream
      discard_q   <= branch_i;
      if (branch_i) begin
        next_addr_q <= {branch_addr_i[`FETCH_ADDR_W-1:2], 2'b00};
        hw_q        <= branch_addr_i[1];
      end else if (mem_req_o) begin
        next_addr_q <= next_addr_q + `FETCH_WORD_BYTES;
        hw_q        <= 1'b0;
      end
    end
  end

  // tag keeps the halfword bit of a redirect target
  always_ff @(posedge clk) begin
    if (mem_req_o) req_addr_q <= {next_addr_q[`FETCH_ADDR_W-1:2], hw_q, 1'b0};
  end

  ////////////////////
  // response path
  ////////////////////

  assign fifo_valid_o = mem_rvalid_i && !discard_q;
  assign fifo_addr_o  = req_addr_q;
  assign fifo_rdata_o = mem_rdata_i;

  // memory answers only what was asked one cycle before
  a_rvalid_has_req : assert property (
    @(posedge clk) disable iff (!rst_n) mem_rvalid_i |-> in_flight_q
  );

endmodule

/* src/issue_reg.sv */
// output side of the prefetcher, holds one instruction for decode until it is taken
`timescale 1ns/1ps
`include "fetch_consts.svh"

module issue_reg (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush_i,
  // from FIFO
  input  logic                     in_valid_i,
  input  logic [`FETCH_ADDR_W-1:0] in_rdata_i,
  input  logic [`FETCH_ADDR_W-1:0] in_addr_i,
  input  fetch_pkg::instr_kind_e   in_kind_i,
  output logic                     in_ready_o,
  // to decode
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic [`FETCH_ADDR_W-1:0] out_rdata_o,
  output logic [`FETCH_ADDR_W-1:0] out_addr_o,
  output fetch_pkg::instr_kind_e   out_kind_o
);

  logic load;

  // free when empty or when decode takes the held one
  assign in_ready_o = !out_valid_o || out_ready_i;
  assign load       = in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= 1'b0;
    end else if (flush_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  // payload only moves on a load
  always_ff @(posedge clk) begin
    if (load) begin
      out_rdata_o <= in_rdata_i;
      out_addr_o  <= in_addr_i;
      out_kind_o  <= in_kind_i;
    end
  end

  // held instruction stays put under back-pressure
  a_hold_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_valid_o && !out_ready_i && !flush_i) |=>
      (out_valid_o && $stable(out_rdata_o) && $stable(out_addr_o) && $stable(out_kind_o))
  );

endmodule

/* src/prefetch_top.sv */
// prefetch subsystem top, connects requester, fetch FIFO and issue register
`timescale 1ns/1ps
`include "fetch_consts.svh"

module prefetch_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     branch_i,
  input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
  // instruction memory
  output logic                     mem_req_o,
  output logic [`FETCH_ADDR_W-1:0] mem_addr_o,
  input  logic                     mem_rvalid_i,
  input  logic [`FETCH_ADDR_W-1:0] mem_rdata_i,
  // decode
  output logic                     instr_valid_o,
  input  logic                     instr_ready_i,
  output logic [`FETCH_ADDR_W-1:0] instr_rdata_o,
  output logic [`FETCH_ADDR_W-1:0] instr_addr_o,
  output fetch_pkg::instr_kind_e   instr_kind_o
);

  // requester to FIFO
  logic                     fifo_in_valid;
  logic                     fifo_in_ready;
  logic [`FETCH_ADDR_W-1:0] fifo_in_addr;
  logic [`FETCH_ADDR_W-1:0] fifo_in_rdata;

  // FIFO to issue register
  logic                     fifo_out_valid;
  logic                     fifo_out_ready;
  logic [`FETCH_ADDR_W-1:0] fifo_out_rdata;
  logic [`FETCH_ADDR_W-1:0] fifo_out_addr;
  fetch_pkg::instr_kind_e   fifo_out_kind;

  fetch_requester requester_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .fifo_ready_i  (fifo_in_ready),
    .fifo_valid_o  (fifo_in_valid),
    .fifo_addr_o   (fifo_in_addr),
    .fifo_rdata_o  (fifo_in_rdata)
  );

  // a redirect clears both buffers for the next cycle
  fetch_fifo fifo_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (branch_i),
    .in_valid_i  (fifo_in_valid),
    .in_addr_i   (fifo_in_addr),
    .in_rdata_i  (fifo_in_rdata),
    .in_ready_o  (fifo_in_ready),
    .out_valid_o (fifo_out_valid),
    .out_ready_i (fifo_out_ready),
    .out_rdata_o (fifo_out_rdata),
    .out_addr_o  (fifo_out_addr),
    .out_kind_o  (fifo_out_kind)
  );

  issue_reg issue_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (branch_i),
    .in_valid_i  (fifo_out_valid),
    .in_rdata_i  (fifo_out_rdata),
    .in_addr_i   (fifo_out_addr),
    .in_kind_i   (fifo_out_kind),
    .in_ready_o  (fifo_out_ready),
    .out_valid_o (instr_valid_o),
    .out_ready_i (instr_ready_i),
    .out_rdata_o (instr_rdata_o),
    .out_addr_o  (instr_addr_o),
    .out_kind_o  (instr_kind_o)
  );

endmodule

/* verification/prefetch_checker.sv */
// testbench checker that models the PC over the memory image and compares what decode consumes
`timescale 1ns/1ps
`include "fetch_consts.svh"

module prefetch_checker (
  input  logic                     clk,
  input  logic                     rst_n,
  // redirect as driven into the DUT
  input  logic                     branch_i,
  input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
  // memory request port
  input  logic                     req_i,
  input  logic [`FETCH_ADDR_W-1:0] req_addr_i,
  // decode port
  input  logic                     valid_i,
  input  logic                     ready_i,
  input  logic [`FETCH_ADDR_W-1:0] rdata_i,
  input  logic [`FETCH_ADDR_W-1:0] addr_i,
  input  fetch_pkg::instr_kind_e   kind_i,
  // running totals for the testbench
  output int                       checks_o,
  output int                       errors_o,
  output int                       seg_count_o,
  output int                       total_o
);

  localparam int IMAGE_WORDS = 64;

  // memory image from the boot address upward that the testbench fills in
  logic [`FETCH_ADDR_W-1:0] image [IMAGE_WORDS];
  logic [`FETCH_ADDR_W-1:0] pc;

  function automatic logic in_image(input logic [`FETCH_ADDR_W-1:0] addr);
    return ((addr - `FETCH_BOOT_ADDR) >> 2) < IMAGE_WORDS;
  endfunction

  // little endian halfword at a byte address
  function automatic logic [15:0] half_at(input logic [`FETCH_ADDR_W-1:0] addr);
    logic [`FETCH_ADDR_W-1:0] word;
    word = image[(addr - `FETCH_BOOT_ADDR) >> 2];
    return addr[1] ? word[31:16] : word[15:0];
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    $display("error: %s is 0x%08h, expected 0x%08h at %0t", name, got, want, $time);
    errors_o++;
  endtask

  ////////////////////
  // PC model
  ////////////////////

  task automatic check_instr();
    logic [15:0]            lo;
    logic [15:0]            hi;
    fetch_pkg::instr_kind_e want_kind;
    if (!in_image(pc) || !in_image(pc + 2)) begin
      $display("the checker PC 0x%08h ran past the loaded memory image", pc);
      errors_o++;
    end else begin
      lo = half_at(pc);
      hi = half_at(pc + 2);
      // length comes from the low two bits at the PC
      if (lo[1:0] != 2'b11) want_kind = fetch_pkg::KIND_COMP;
      else want_kind = fetch_pkg::KIND_FULL;
      checks_o++;
      if (addr_i !== pc) report_value("instr_addr_o", addr_i, pc);
      if (kind_i !== want_kind) report_value("instr_kind_o", 32'(kind_i), 32'(want_kind));
      if (want_kind == fetch_pkg::KIND_FULL) begin
        if (rdata_i !== {hi, lo}) report_value("instr_rdata_o", rdata_i, {hi, lo});
        pc = pc + 4;
      end else begin
        // upper half of a compressed one is don't care
        if (rdata_i[15:0] !== lo) report_value("instr_rdata_o[15:0]", {16'h0, rdata_i[15:0]},
                                               {16'h0, lo});
        pc = pc + 2;
      end
    end
    seg_count_o++;
    total_o++;
  endtask

  // sampled mid cycle while the handshake signals are stable
  always @(negedge clk) begin
    if (!rst_n) begin
      pc          = `FETCH_BOOT_ADDR;
      checks_o    = 0;
      errors_o    = 0;
      seg_count_o = 0;
      total_o     = 0;
    end else begin
      // every read goes to a word address
      if (req_i && req_addr_i[1:0] !== 2'b00) begin
        report_value("mem_addr_o[1:0]", {30'h0, req_addr_i[1:0]}, 32'h0);
      end
      // an instruction taken in the branch cycle still belongs to the old stream
      if (valid_i && ready_i) check_instr();
      if (branch_i) begin
        pc          = branch_addr_i;
        seg_count_o = 0;
      end
    end
  end

endmodule

/* verification/prefetch_input.txt */
# first value is the word count, then memory words in hex from the boot address 0x80
# b <cycle after reset> <target hex> is a redirect, n <count> is instructions due after the last one
16
00100513
05934501
46050020
00300693
47814709
00400813
08938082
49050050
00600993
00700a13
0b134a85
4b050080
00900b93
4c054c85
00a00c13
00010001
b 14 00000086
b 34 0000009e
b 54 00000080
n 20

/* verification/prefetch_tb.sv */
// testbench top, runs the prefetcher against a memory model with stimulus from the input file
`timescale 1ns/1ps
`include "fetch_consts.svh"

module prefetch_tb;

  localparam int MEM_WORDS = 64;
  localparam int MAX_BR    = 8;

  logic                   clk;
  logic                   rst_n;
  logic                   branch;
  logic [31:0]            branch_addr;
  logic                   mem_req;
  logic [31:0]            mem_addr;
  logic                   mem_rvalid;
  logic [31:0]            mem_rdata;
  logic                   instr_valid;
  logic                   instr_ready;
  logic [31:0]            instr_rdata;
  logic [31:0]            instr_addr;
  fetch_pkg::instr_kind_e instr_kind;

  // stimulus from the data file
  logic [31:0] mem [MEM_WORDS];
  int          br_cycle [MAX_BR];
  logic [31:0] br_addr [MAX_BR];
  int          word_count;
  int          br_count;
  int          expected_count;
  int          load_errors;

  // request seen mid cycle, answered on the next edge
  logic        pend_req;
  logic [31:0] pend_addr;

  int          cycles;
  int          limit;
  int          br_idx;
  int          fails;
  int          checks;
  int          errors;
  int          seg_count;
  int          total;
  logic        done;
  integer      seed;
  logic [31:0] rnd;

  prefetch_top dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .mem_req_o     (mem_req),
    .mem_addr_o    (mem_addr),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rdata_i   (mem_rdata),
    .instr_valid_o (instr_valid),
    .instr_ready_i (instr_ready),
    .instr_rdata_o (instr_rdata),
    .instr_addr_o  (instr_addr),
    .instr_kind_o  (instr_kind)
  );

  prefetch_checker checker_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .req_i         (mem_req),
    .req_addr_i    (mem_addr),
    .valid_i       (instr_valid),
    .ready_i       (instr_ready),
    .rdata_i       (instr_rdata),
    .addr_i        (instr_addr),
    .kind_i        (instr_kind),
    .checks_o      (checks),
    .errors_o      (errors),
    .seg_count_o   (seg_count),
    .total_o       (total)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////
  // memory model
  ////////////////////

  // words outside the image, mixes every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h6b8e_24c7;
  endfunction

  function automatic logic [31:0] mem_read(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - `FETCH_BOOT_ADDR) >> 2;
    if (idx < MEM_WORDS) return mem[idx];
    return fill_word(addr);
  endfunction

  always @(negedge clk) begin
    pend_req  = mem_req;
    pend_addr = mem_addr;
  end

  task automatic load_stimulus();
    integer          fd;
    integer          n;
    int              c;
    int              words_seen;
    logic [31:0]     val;
    logic [8*96-1:0] line;
    logic [8*8-1:0]  tok;
    words_seen     = 0;
    word_count     = -1;
    br_count       = 0;
    expected_count = -1;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(`FETCH_BOOT_ADDR + 4 * i);
    fd = $fopen("verification/prefetch_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file verification/prefetch_input.txt");
      load_errors++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        tok = '0;
        n   = $sscanf(line, "%s", tok);
        // lines led by # are comments
        if (n == 1 && tok != "#") begin
          if (tok == "b") begin
            if ($sscanf(line, "b %d %h", c, val) == 2 && br_count < MAX_BR) begin
              br_cycle[br_count] = c;
              br_addr[br_count]  = val;
              br_count++;
            end
          end else if (tok == "n") begin
            n = $sscanf(line, "n %d", expected_count);
          end else if (word_count < 0) begin
            n = $sscanf(line, "%d", word_count);
          end else if (words_seen < word_count && words_seen < MEM_WORDS) begin
            n = $sscanf(line, "%h", val);
            mem[words_seen] = val;
            words_seen++;
          end
        end
      end
      $fclose(fd);
      if (words_seen != word_count || expected_count < 0) begin
        $display("the stimulus file is incomplete");
        load_errors++;
      end
    end
    for (int i = 0; i < MEM_WORDS; i++) checker_i.image[i] = mem[i];
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic drive_cycle();
    mem_rvalid = pend_req;
    mem_rdata  = pend_req ? mem_read(pend_addr) : '0;
    branch     = 1'b0;
    if (br_idx < br_count && br_cycle[br_idx] == cycles) begin
      branch      = 1'b1;
      branch_addr = br_addr[br_idx];
      br_idx++;
    end
    // decode ready about 70% of cycles
    rnd         = $random(seed);
    instr_ready = (rnd % 100) < 70;
  endtask

  initial begin
    rst_n       = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    mem_rvalid  = 1'b0;
    mem_rdata   = '0;
    instr_ready = 1'b0;
    seed        = 32'hc8d465f9;
    cycles      = 0;
    br_idx      = 0;
    done        = 1'b0;
    load_errors = 0;
    load_stimulus();
    limit = (load_errors == 0) ? 20 * word_count + 50 * br_count + 100 : 0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    while (!done && cycles < limit) begin
      @(posedge clk);
      #2;
      cycles++;
      drive_cycle();
      // segment count restarts on the edge after the last redirect
      done = (br_idx == br_count) && !branch && (seg_count >= expected_count);
    end
    if (!done && load_errors == 0) begin
      $display("timeout, the run did not finish within %0d cycles", limit);
    end
    fails = errors + load_errors + (done ? 0 : 1);
    $display("checks %0d, consumed %0d, final segment %0d of %0d, errors %0d",
             checks, total, seg_count, expected_count, fails);
    if (fails == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+src
src/fetch_pkg.sv
src/fetch_requester.sv
src/fetch_fifo.sv
src/issue_reg.sv
src/prefetch_top.sv
verification/prefetch_checker.sv
verification/prefetch_tb.sv
